/* logic/tmu_pkg.sv */
// Texture-mapping unit pixel back end shared definitions
// Widths, CSR register map, pixel and burst payloads, finish FSM states
package tmu_pkg;

	// Framebuffer and burst geometry
	localparam int FB_ADR_W = 24;                      // 16-bit word address
	localparam int BURST_PIX = 4;                      // Pixels per write burst
	localparam int SLOT_W = $clog2(BURST_PIX);         // Pixel slot index within a burst
	localparam int BURST_ADR_W = FB_ADR_W - SLOT_W;    // 64-bit word address

	// CSR bus
	localparam int CSR_A_W = 4;
	localparam int CSR_D_W = 32;

	// Register map, word addresses
	localparam logic [CSR_A_W-1:0] REG_CTRL = 4'd0;    // W: bit0 finish, bit1 key enable
	localparam logic [CSR_A_W-1:0] REG_BRIGHT = 4'd1;
	localparam logic [CSR_A_W-1:0] REG_KEY = 4'd2;

	// Brightness 0-63, full scale out of reset
	localparam int BRIGHT_W = 6;
	localparam logic [BRIGHT_W-1:0] BRIGHT_RST = 6'd63;

	typedef logic [15:0] color_t;                      // RGB565

	typedef struct packed {
		color_t                color;
		logic [FB_ADR_W-1:0]   adr;
	} pix_t;

	typedef struct packed {
		logic [BURST_ADR_W-1:0]   adr;
		logic [2*BURST_PIX-1:0]   sel;                 // Byte selects, two per pixel
		logic [16*BURST_PIX-1:0]  dat;                 // Pixel i in bits 16i+15:16i
	} burst_t;

	// Finish sequence
	typedef enum logic [1:0] {
		IDLE,
		WAIT_DRAIN,
		FLUSH,
		WAIT_FLUSH
	} ctl_state_t;

	typedef struct packed {
		logic [BRIGHT_W-1:0]   bright;
		logic                  key_en;
		color_t                key;
	} decay_cfg_t;

endpackage

/* logic/pipe_buffer.sv */
// One-entry registered pipeline stage
// Carries any payload type over the stb/ack handshake
module pipe_buffer #(
	parameter type payload_t = logic
) (
	input  logic      sys_clk,
	input  logic      sys_rst,
	input  logic      pipe_stb_i,
	output logic      pipe_ack_o,
	input  payload_t  dat_i,
	output logic      pipe_stb_o,
	input  logic      pipe_ack_i,
	output payload_t  dat_o,
	output logic      busy_o
);
	assign pipe_ack_o = ~pipe_stb_o | pipe_ack_i;    // Empty, or emptying this cycle
	assign busy_o = pipe_stb_o;

	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			pipe_stb_o <= 1'b0;
		else if (pipe_stb_i & pipe_ack_o)
			pipe_stb_o <= 1'b1;
		else if (pipe_ack_i)
			pipe_stb_o <= 1'b0;
	end

	always_ff @(posedge sys_clk) begin
		if (pipe_stb_i & pipe_ack_o)
			dat_o <= dat_i;
	end

	// Upstream keeps its item stable until it moves
	a_hold: assert property (@(posedge sys_clk) disable iff (sys_rst)
		pipe_stb_i && !pipe_ack_o |=> pipe_stb_i && $stable(dat_i));

endmodule

/* logic/tmu_ctlif.sv */
// TMU control interface
// Holds brightness and chroma-key registers on the CSR bus and runs the
// finish sequence: drain, flush the partial burst, drain again, interrupt
module tmu_ctlif (
	input  logic                         sys_clk,
	input  logic                         sys_rst,
	input  logic [tmu_pkg::CSR_A_W-1:0]  csr_a_i,
	input  logic                         csr_we_i,
	input  logic [tmu_pkg::CSR_D_W-1:0]  csr_di_i,
	input  logic [3:0]                   stage_busy_i,
	output logic [tmu_pkg::CSR_D_W-1:0]  csr_do_o,
	output logic                         irq_o,
	output tmu_pkg::decay_cfg_t          cfg_o,
	output logic                         flush_o
);
	tmu_pkg::ctl_state_t state;
	tmu_pkg::ctl_state_t next_state;
	logic pipe_busy;
	logic busy;
	logic finish;
	logic [tmu_pkg::CSR_D_W-1:0] rd_dat;

	assign pipe_busy = |stage_busy_i;
	assign busy = (state != tmu_pkg::IDLE);
	// Finish is ignored while a sequence is running
	assign finish = csr_we_i & (csr_a_i == tmu_pkg::REG_CTRL) & csr_di_i[0] & ~busy;

	// Register writes
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			cfg_o.bright <= tmu_pkg::BRIGHT_RST;
			cfg_o.key_en <= 1'b0;
			cfg_o.key <= '0;
		end else if (csr_we_i) begin
			case (csr_a_i)
				tmu_pkg::REG_CTRL:   cfg_o.key_en <= csr_di_i[1];
				tmu_pkg::REG_BRIGHT: cfg_o.bright <= csr_di_i[tmu_pkg::BRIGHT_W-1:0];
				tmu_pkg::REG_KEY:    cfg_o.key <= csr_di_i[15:0];
				default: ;
			endcase
		end
	end

	// Read mux, registered below for one cycle of latency
	always_comb begin
		rd_dat = '0;
		case (csr_a_i)
			tmu_pkg::REG_CTRL: begin
				rd_dat[0] = busy;
				rd_dat[1] = cfg_o.key_en;
			end
			tmu_pkg::REG_BRIGHT: rd_dat[tmu_pkg::BRIGHT_W-1:0] = cfg_o.bright;
			tmu_pkg::REG_KEY:    rd_dat[15:0] = cfg_o.key;
			default: ;
		endcase
	end

	always_ff @(posedge sys_clk) begin
		csr_do_o <= rd_dat;
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state <= tmu_pkg::IDLE;
			irq_o <= 1'b0;
		end else begin
			state <= next_state;
			irq_o <= (state == tmu_pkg::WAIT_FLUSH) & ~pipe_busy;   // Lands on first IDLE cycle
		end
	end

	always_comb begin
		next_state = state;
		flush_o = 1'b0;
		case (state)
			tmu_pkg::IDLE:       if (finish) next_state = tmu_pkg::WAIT_DRAIN;
			tmu_pkg::WAIT_DRAIN: if (~pipe_busy) next_state = tmu_pkg::FLUSH;
			tmu_pkg::FLUSH: begin
				flush_o = 1'b1;
				next_state = tmu_pkg::WAIT_FLUSH;
			end
			tmu_pkg::WAIT_FLUSH: if (~pipe_busy) next_state = tmu_pkg::IDLE;
			default: next_state = tmu_pkg::IDLE;
		endcase
	end

	// Flush lands on a drained pipeline
	a_flush_drained: assert property (@(posedge sys_clk) disable iff (sys_rst)
		flush_o |-> !pipe_busy);

endmodule

/* logic/tmu_decay.sv */
// TMU decay stage
// Scales each RGB565 channel by brightness and drops chroma-keyed pixels
module tmu_decay (
	input  logic                 sys_clk,
	input  logic                 sys_rst,
	input  tmu_pkg::decay_cfg_t  cfg_i,
	input  logic                 pipe_stb_i,
	output logic                 pipe_ack_o,
	input  tmu_pkg::pix_t        pix_i,
	output logic                 pipe_stb_o,
	input  logic                 pipe_ack_i,
	output tmu_pkg::pix_t        pix_o,
	output logic                 busy_o
);
	logic [6:0] mul;              // Brightness plus one, 1-64
	logic [11:0] r_m;
	logic [12:0] g_m;
	logic [11:0] b_m;
	logic drop;
	logic take;

	always_comb begin
		mul = {1'b0, cfg_i.bright} + 7'd1;
		r_m = pix_i.color[15:11] * mul;
		g_m = pix_i.color[10:5] * mul;
		b_m = pix_i.color[4:0] * mul;
	end

	assign drop = cfg_i.key_en & (pix_i.color == cfg_i.key);
	assign pipe_ack_o = ~pipe_stb_o | pipe_ack_i;
	assign take = pipe_stb_i & pipe_ack_o;
	assign busy_o = pipe_stb_o;

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			pipe_stb_o <= 1'b0;
		end else begin
			if (pipe_ack_i)
				pipe_stb_o <= 1'b0;
			if (take)
				pipe_stb_o <= ~drop;    // Keyed pixel is swallowed here
		end
	end

	always_ff @(posedge sys_clk) begin
		if (take & ~drop) begin
			pix_o.color <= {r_m[10:6], g_m[11:6], b_m[10:6]};   // Divide by 64
			pix_o.adr <= pix_i.adr;
		end
	end

endmodule

/* logic/tmu_burst.sv */
// TMU burst assembler
// Gathers pixels of one burst address into data and byte selects, emits the
// burst when a pixel for another burst arrives or on flush
module tmu_burst (
	input  logic             sys_clk,
	input  logic             sys_rst,
	input  logic             flush_i,
	input  logic             pipe_stb_i,
	output logic             pipe_ack_o,
	input  tmu_pkg::pix_t    pix_i,
	output logic             pipe_stb_o,
	input  logic             pipe_ack_i,
	output tmu_pkg::burst_t  burst_o,
	output logic             busy_o
);
	logic [tmu_pkg::BURST_ADR_W-1:0] cur_adr;
	logic [2*tmu_pkg::BURST_PIX-1:0] cur_sel;
	logic [16*tmu_pkg::BURST_PIX-1:0] cur_dat;
	logic [tmu_pkg::BURST_ADR_W-1:0] pix_badr;
	logic [tmu_pkg::SLOT_W-1:0] slot;
	logic fresh;
	logic merge;
	logic out_free;
	logic take;
	logic emit;

	assign pix_badr = pix_i.adr[tmu_pkg::FB_ADR_W-1:tmu_pkg::SLOT_W];
	assign slot = pix_i.adr[tmu_pkg::SLOT_W-1:0];
	assign fresh = (cur_sel == '0);                      // Nothing gathered yet
	assign merge = ~fresh & (pix_badr == cur_adr);
	assign out_free = ~pipe_stb_o | pipe_ack_i;

	// A pixel for a new burst needs room to push out the old one
	assign pipe_ack_o = fresh | merge | out_free;
	assign take = pipe_stb_i & pipe_ack_o;
	assign emit = ~fresh & out_free & ((take & ~merge) | flush_i);
	assign busy_o = pipe_stb_o;

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			pipe_stb_o <= 1'b0;
			cur_sel <= '0;
		end else begin
			if (pipe_ack_i)
				pipe_stb_o <= 1'b0;
			if (emit)
				pipe_stb_o <= 1'b1;
			if (take) begin
				if (!merge)
					cur_sel <= '0;
				cur_sel[slot*2 +: 2] <= 2'b11;
			end else if (emit) begin
				cur_sel <= '0;                           // Flushed
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (take) begin
			if (!merge) begin
				cur_adr <= pix_badr;
				cur_dat <= '0;
			end
			cur_dat[slot*16 +: 16] <= pix_i.color;       // Later pixel overwrites
		end
		if (emit) begin
			burst_o.adr <= cur_adr;
			burst_o.sel <= cur_sel;
			burst_o.dat <= cur_dat;
		end
	end

	// The control FSM only flushes a drained pipeline
	a_flush_idle: assert property (@(posedge sys_clk) disable iff (sys_rst)
		flush_i |-> !pipe_stb_o && !pipe_stb_i);

endmodule

/* logic/tmu_back_top.sv */
// TMU pixel back end top level
// Control block, decay, pixel buffer, burst assembler and output buffer
module tmu_back_top (
	input  logic                         sys_clk,
	input  logic                         sys_rst,
	input  logic [tmu_pkg::CSR_A_W-1:0]  csr_a_i,
	input  logic                         csr_we_i,
	input  logic [tmu_pkg::CSR_D_W-1:0]  csr_di_i,
	output logic [tmu_pkg::CSR_D_W-1:0]  csr_do_o,
	output logic                         irq_o,
	input  logic                         pix_stb_i,
	input  tmu_pkg::pix_t                pix_i,
	output logic                         pix_ack_o,
	output logic                         wr_stb_o,
	output tmu_pkg::burst_t              wr_o,
	input  logic                         wr_ack_i
);
	tmu_pkg::decay_cfg_t cfg;
	logic flush;

	logic decay_busy;
	logic decay_stb;
	logic decay_ack;
	tmu_pkg::pix_t decay_pix;

	logic pix_buf_busy;
	logic pix_buf_stb;
	logic pix_buf_ack;
	tmu_pkg::pix_t pix_buf_pix;

	logic burst_busy;
	logic burst_stb;
	logic burst_ack;
	tmu_pkg::burst_t burst_dat;

	logic out_buf_busy;

	tmu_ctlif ctlif (
		.sys_clk      (sys_clk),
		.sys_rst      (sys_rst),
		.csr_a_i      (csr_a_i),
		.csr_we_i     (csr_we_i),
		.csr_di_i     (csr_di_i),
		.stage_busy_i ({out_buf_busy, burst_busy, pix_buf_busy, decay_busy}),
		.csr_do_o     (csr_do_o),
		.irq_o        (irq_o),
		.cfg_o        (cfg),
		.flush_o      (flush)
	);

	tmu_decay decay (
		.sys_clk    (sys_clk),
		.sys_rst    (sys_rst),
		.cfg_i      (cfg),
		.pipe_stb_i (pix_stb_i),
		.pipe_ack_o (pix_ack_o),
		.pix_i      (pix_i),
		.pipe_stb_o (decay_stb),
		.pipe_ack_i (decay_ack),
		.pix_o      (decay_pix),
		.busy_o     (decay_busy)
	);

	pipe_buffer #(.payload_t(tmu_pkg::pix_t)) pix_buf (
		.sys_clk    (sys_clk),
		.sys_rst    (sys_rst),
		.pipe_stb_i (decay_stb),
		.pipe_ack_o (decay_ack),
		.dat_i      (decay_pix),
		.pipe_stb_o (pix_buf_stb),
		.pipe_ack_i (pix_buf_ack),
		.dat_o      (pix_buf_pix),
		.busy_o     (pix_buf_busy)
	);

	tmu_burst burst (
		.sys_clk    (sys_clk),
		.sys_rst    (sys_rst),
		.flush_i    (flush),
		.pipe_stb_i (pix_buf_stb),
		.pipe_ack_o (pix_buf_ack),
		.pix_i      (pix_buf_pix),
		.pipe_stb_o (burst_stb),
		.pipe_ack_i (burst_ack),
		.burst_o    (burst_dat),
		.busy_o     (burst_busy)
	);

	// Output register toward the write port
	pipe_buffer #(.payload_t(tmu_pkg::burst_t)) out_buf (
		.sys_clk    (sys_clk),
		.sys_rst    (sys_rst),
		.pipe_stb_i (burst_stb),
		.pipe_ack_o (burst_ack),
		.dat_i      (burst_dat),
		.pipe_stb_o (wr_stb_o),
		.pipe_ack_i (wr_ack_i),
		.dat_o      (wr_o),
		.busy_o     (out_buf_busy)
	);

endmodule

/* tb/tmu_checks.svh */
// Compare tasks for the TMU back end testbench
// One task per kind of result, typed to the DUT's burst and CSR data
`ifndef TMU_CHECKS_SVH
`define TMU_CHECKS_SVH

// Burst on the write port against the model's next burst
task automatic check_burst(input tmu_pkg::burst_t got, input tmu_pkg::burst_t exp,
		input int idx);
	if (got !== exp) begin
		abort_run($sformatf(
			"[ERROR] wr_o burst %0d: got adr %h sel %h dat %h, expected adr %h sel %h dat %h",
			idx, got.adr, got.sel, got.dat, exp.adr, exp.sel, exp.dat));
	end
endtask

// CSR read data, reg_name tells which register was addressed
task automatic check_csr(input logic [tmu_pkg::CSR_D_W-1:0] got,
		input logic [tmu_pkg::CSR_D_W-1:0] exp, input string reg_name);
	if (got !== exp) begin
		abort_run($sformatf("[ERROR] csr_do_o (%s): got %h, expected %h",
			reg_name, got, exp));
	end
endtask

`endif

/* tb/tb_tmu_back.sv */
// TMU pixel back end testbench
// Runs a pixel table through the back end under random write-port stalls,
// checks bursts against a reference model, CSR reads and the finish interrupt
module tb_tmu_back;

	localparam int NUM_STIM = 20;
	localparam int NUM_PHASES = 4;
	localparam int IRQ_WAIT = 100;                     // Cycles from finish to interrupt

	typedef struct packed {
		tmu_pkg::color_t               color;
		logic [tmu_pkg::FB_ADR_W-1:0]  adr;
		logic                          finish_after;   // Finish write follows this pixel
	} stim_t;

	logic sys_clk = 1'b0;
	logic sys_rst;
	logic [tmu_pkg::CSR_A_W-1:0] csr_a_i;
	logic csr_we_i;
	logic [tmu_pkg::CSR_D_W-1:0] csr_di_i;
	logic [tmu_pkg::CSR_D_W-1:0] csr_do_o;
	logic irq_o;
	logic pix_stb_i;
	tmu_pkg::pix_t pix_i;
	logic pix_ack_o;
	logic wr_stb_o;
	tmu_pkg::burst_t wr_o;
	logic wr_ack_i;

	stim_t stim [NUM_STIM];
	tmu_pkg::burst_t exp_q [$];
	int phase_bursts [NUM_PHASES];                     // Bursts expected by the end of each frame
	int exp_total;
	int rx_cnt = 0;
	int irq_cnt = 0;
	logic irq_last = 1'b0;
	logic [15:0] lfsr = 16'd19650;

	always #20 sys_clk = ~sys_clk;

	tmu_back_top tmu_back_top_inst (
		.sys_clk   (sys_clk),
		.sys_rst   (sys_rst),
		.csr_a_i   (csr_a_i),
		.csr_we_i  (csr_we_i),
		.csr_di_i  (csr_di_i),
		.csr_do_o  (csr_do_o),
		.irq_o     (irq_o),
		.pix_stb_i (pix_stb_i),
		.pix_i     (pix_i),
		.pix_ack_o (pix_ack_o),
		.wr_stb_o  (wr_stb_o),
		.wr_o      (wr_o),
		.wr_ack_i  (wr_ack_i)
	);

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("tests failed");
		$fatal(1);
	endtask

	`include "tmu_checks.svh"

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	// Channel times brightness plus one, divided by 64
	function automatic tmu_pkg::color_t decay_color(input tmu_pkg::color_t c,
			input logic [5:0] bright);
		int m;
		int r;
		int g;
		int bl;
		m = bright + 1;
		r = (c[15:11] * m) >> 6;
		g = (c[10:5] * m) >> 6;
		bl = (c[4:0] * m) >> 6;
		return {r[4:0], g[5:0], bl[4:0]};
	endfunction

	function automatic tmu_pkg::decay_cfg_t phase_cfg(input int phase);
		tmu_pkg::decay_cfg_t cfg;
		cfg.key = 16'hF81F;
		cfg.key_en = (phase == 2);
		case (phase)
			1: cfg.bright = 6'd31;
			3: cfg.bright = 6'd47;
			default: cfg.bright = 6'd63;
		endcase
		return cfg;
	endfunction

	task automatic load_table();
		stim[0] = {16'hF800, 24'h000100, 1'b0};    // Phase 0, full burst, colours kept
		stim[1] = {16'h07E0, 24'h000101, 1'b0};
		stim[2] = {16'h001F, 24'h000102, 1'b0};
		stim[3] = {16'hFFFF, 24'h000103, 1'b0};
		stim[4] = {16'h1234, 24'h000104, 1'b1};
		stim[5] = {16'hFFFF, 24'h000200, 1'b0};    // Phase 1, brightness 31
		stim[6] = {16'h8410, 24'h000201, 1'b0};
		stim[7] = {16'h7BEF, 24'h000203, 1'b0};
		stim[8] = {16'h5A5A, 24'h000205, 1'b1};
		stim[9] = {16'hF81F, 24'h000300, 1'b0};    // Phase 2, chroma key on
		stim[10] = {16'h1234, 24'h000301, 1'b0};
		stim[11] = {16'hF81F, 24'h000302, 1'b0};
		stim[12] = {16'hF81F, 24'h000304, 1'b0};   // Whole burst keyed out
		stim[13] = {16'hF81F, 24'h000305, 1'b0};
		stim[14] = {16'hABCD, 24'h000308, 1'b1};
		stim[15] = {16'h1111, 24'h000400, 1'b0};   // Phase 3, overwrite and revisit
		stim[16] = {16'h2222, 24'h000402, 1'b0};
		stim[17] = {16'h3333, 24'h000400, 1'b0};
		stim[18] = {16'h4444, 24'h000503, 1'b0};
		stim[19] = {16'h6666, 24'h000401, 1'b1};
	endtask

	// Reference model of decay and burst gathering over the whole table
	task automatic build_expected();
		tmu_pkg::decay_cfg_t cfg;
		tmu_pkg::burst_t cur;
		int phase;
		int slot;
		phase = 0;
		cur = '0;
		for (int i = 0; i < NUM_STIM; i++) begin
			cfg = phase_cfg(phase);
			if (!(cfg.key_en && stim[i].color == cfg.key)) begin
				if (cur.sel != 0 && cur.adr != stim[i].adr[tmu_pkg::FB_ADR_W-1:2]) begin
					exp_q.push_back(cur);
					cur = '0;
				end
				cur.adr = stim[i].adr[tmu_pkg::FB_ADR_W-1:2];
				slot = stim[i].adr[1:0];
				cur.dat[slot*16 +: 16] = decay_color(stim[i].color, cfg.bright);
				cur.sel[slot*2 +: 2] = 2'b11;
			end
			if (stim[i].finish_after) begin
				if (cur.sel != 0)
					exp_q.push_back(cur);
				cur = '0;
				phase_bursts[phase] = exp_q.size();
				phase++;
			end
		end
	endtask

	task automatic csr_write(input logic [tmu_pkg::CSR_A_W-1:0] a,
			input logic [tmu_pkg::CSR_D_W-1:0] d);
		@(negedge sys_clk);
		csr_a_i = a;
		csr_di_i = d;
		csr_we_i = 1'b1;
		@(negedge sys_clk);
		csr_we_i = 1'b0;
	endtask

	task automatic csr_read(input logic [tmu_pkg::CSR_A_W-1:0] a,
			output logic [tmu_pkg::CSR_D_W-1:0] d);
		@(negedge sys_clk);
		csr_a_i = a;
		csr_we_i = 1'b0;
		@(negedge sys_clk);
		d = csr_do_o;                                  // Registered one cycle after address
	endtask

	task automatic apply_cfg(input tmu_pkg::decay_cfg_t cfg);
		csr_write(tmu_pkg::REG_BRIGHT, {26'd0, cfg.bright});
		csr_write(tmu_pkg::REG_KEY, {16'd0, cfg.key});
		csr_write(tmu_pkg::REG_CTRL, {30'd0, cfg.key_en, 1'b0});
	endtask

	// Leaves stb high so the next pixel can follow back to back
	task automatic send_pixel(input int idx);
		@(negedge sys_clk);
		pix_stb_i = 1'b1;
		pix_i.color = stim[idx].color;
		pix_i.adr = stim[idx].adr;
		@(posedge sys_clk);
		while (!pix_ack_o)
			@(posedge sys_clk);
	endtask

	task automatic run_finish(input tmu_pkg::decay_cfg_t cfg, input int irq_target);
		logic [tmu_pkg::CSR_D_W-1:0] rd;
		int t;
		@(negedge sys_clk);
		pix_stb_i = 1'b0;
		csr_write(tmu_pkg::REG_CTRL, {30'd0, cfg.key_en, 1'b1});
		csr_read(tmu_pkg::REG_CTRL, rd);
		check_csr(rd, {30'd0, cfg.key_en, 1'b1}, "ctrl during finish");
		t = 0;
		while (irq_cnt < irq_target && t < IRQ_WAIT) begin
			@(negedge sys_clk);
			t++;
		end
		if (irq_cnt < irq_target)
			abort_run("no interrupt arrived after the finish write");
		if (rx_cnt != phase_bursts[irq_target-1])
			abort_run("interrupt arrived before all bursts of the frame were written");
		csr_read(tmu_pkg::REG_CTRL, rd);
		check_csr(rd, {30'd0, cfg.key_en, 1'b0}, "ctrl after interrupt");
	endtask

	// Interrupt must be a single-cycle pulse
	always @(posedge sys_clk) begin
		if (irq_o === 1'b1 && irq_last)
			abort_run("interrupt stayed high for more than one cycle");
		if (irq_o === 1'b1)
			irq_cnt++;
		irq_last = (irq_o === 1'b1);
	end

	// Write port with 0 to 3 stall cycles before each ack
	initial begin : write_port
		logic [1:0] stall;
		wr_ack_i = 1'b0;
		forever begin
			@(negedge sys_clk);
			wr_ack_i = 1'b0;
			if (wr_stb_o === 1'b1) begin
				lfsr = lfsr_step(lfsr);
				stall[0] = lfsr[0];
				lfsr = lfsr_step(lfsr);
				stall[1] = lfsr[0];
				repeat (stall) @(negedge sys_clk);
				if (exp_q.size() == 0)
					abort_run("a burst arrived when none was expected");
				check_burst(wr_o, exp_q.pop_front(), rx_cnt);
				rx_cnt++;
				wr_ack_i = 1'b1;
			end
		end
	end

	initial begin : watchdog
		repeat (NUM_STIM * 200) @(posedge sys_clk);
		abort_run("watchdog expired before the test sequence completed");
	end

	initial begin : main
		logic [tmu_pkg::CSR_D_W-1:0] rd;
		tmu_pkg::decay_cfg_t cfg;
		int phase;
		sys_rst = 1'b1;
		csr_a_i = '0;
		csr_we_i = 1'b0;
		csr_di_i = '0;
		pix_stb_i = 1'b0;
		pix_i = '0;
		load_table();
		build_expected();
		exp_total = exp_q.size();
		repeat (4) @(posedge sys_clk);
		@(negedge sys_clk);
		sys_rst = 1'b0;

		// Reset values and a register read-back
		csr_read(tmu_pkg::REG_CTRL, rd);
		check_csr(rd, 32'h0, "ctrl");
		csr_read(tmu_pkg::REG_BRIGHT, rd);
		check_csr(rd, 32'd63, "bright");
		csr_read(tmu_pkg::REG_KEY, rd);
		check_csr(rd, 32'h0, "key");
		csr_write(tmu_pkg::REG_KEY, 32'h0000_BEEF);
		csr_read(tmu_pkg::REG_KEY, rd);
		check_csr(rd, 32'h0000_BEEF, "key");

		phase = 0;
		for (int i = 0; i < NUM_STIM; i++) begin
			cfg = phase_cfg(phase);
			if (i == 0 || stim[i-1].finish_after)
				apply_cfg(cfg);
			send_pixel(i);
			if (stim[i].finish_after) begin
				run_finish(cfg, phase + 1);
				phase++;
			end
		end

		if (rx_cnt == exp_total && irq_cnt == NUM_PHASES) begin
			$display("all tests passed");
			$finish;
		end else begin
			abort_run($sformatf("%0d of %0d bursts and %0d of %0d interrupts arrived",
				rx_cnt, exp_total, irq_cnt, NUM_PHASES));
		end
	end

endmodule

/* all.f */
+incdir+tb
logic/tmu_pkg.sv
logic/pipe_buffer.sv
logic/tmu_ctlif.sv
logic/tmu_decay.sv
logic/tmu_burst.sv
logic/tmu_back_top.sv
tb/tb_tmu_back.sv

/* Bender.yml */
package:
  name: tmu_back

sources:
  - files:
      - logic/tmu_pkg.sv
      - logic/pipe_buffer.sv
      - logic/tmu_ctlif.sv
      - logic/tmu_decay.sv
      - logic/tmu_burst.sv
      - logic/tmu_back_top.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_tmu_back.sv
